// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sram_controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module sram_controller_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vsram_controller_tb > "$log_file" 2>&1
run_status=$?
cat "$log_file"

# The log decides the verdict, the exit status backs it up
if grep -q "Testbench failed" "$log_file"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== sim/sram_controller_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_controller_tb;

    localparam int nch           = buffer_pkg::num_channels;
    localparam int depth         = buffer_pkg::buffer_depth;
    localparam int num_cycles    = 2000;
    localparam int ready_timeout = 50;      // Cycles allowed for wr_ready after reset
    localparam int hold_timeout  = 500;     // Longest wait of a beat on a full channel

    logic                              clk;
    logic                              reset;
    flow_pkg::write_beat_t             wr_beat;
    flow_pkg::alloc_req_t              alloc;
    flow_pkg::drain_req_t              drain_rsv;
    flow_pkg::drain_cmd_t              drain;
    logic                              wr_ready;
    buffer_pkg::level_t [nch-1:0]      space_free;
    buffer_pkg::level_t [nch-1:0]      data_avail;
    logic [nch-1:0]                    rd_valid;
    buffer_pkg::data_t                 rd_data;

    // Reference model with one queue and two reservation counts per channel
    buffer_pkg::data_t model_q [nch][$];
    int                alloc_out [nch];
    int                rsv_out [nch];
    buffer_pkg::data_t exp_rd_data;         // Last drained beat

    sram_controller u_dut (
        .clk        (clk),
        .reset      (reset),
        .wr_beat    (wr_beat),
        .alloc      (alloc),
        .drain_rsv  (drain_rsv),
        .drain      (drain),
        .wr_ready   (wr_ready),
        .space_free (space_free),
        .data_avail (data_avail),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================

    task automatic fail_and_stop();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_level(input string name, input buffer_pkg::level_t expected,
                               input buffer_pkg::level_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_data(input string name, input buffer_pkg::data_t expected,
                              input buffer_pkg::data_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            fail_and_stop();
        end
    endtask

    // All registered outputs against the model
    task automatic check_outputs(input int cyc);
        for (int ch = 0; ch < nch; ch++) begin
            check_level($sformatf("space_free[%0d] cycle %0d", ch, cyc),
                        buffer_pkg::level_t'(depth - model_q[ch].size() - alloc_out[ch]),
                        space_free[ch]);
            check_level($sformatf("data_avail[%0d] cycle %0d", ch, cyc),
                        buffer_pkg::level_t'(model_q[ch].size() - rsv_out[ch]),
                        data_avail[ch]);
            check_flag($sformatf("rd_valid[%0d] cycle %0d", ch, cyc),
                       model_q[ch].size() != 0, rd_valid[ch]);
        end
        check_data($sformatf("rd_data cycle %0d", cyc), exp_rd_data, rd_data);
    endtask

    // ======================================================================
    // Stimulus and model update
    // ======================================================================

    initial begin
        int                      wait_cycles;
        int                      hold_cycles;
        int                      write_pct;
        int                      drain_pct;
        int                      limit;
        bit                      pushed;
        bit                      holding;
        buffer_pkg::channel_id_t pick;

        void'($urandom(32'h3f49));
        hold_cycles = 0;
        holding     = 1'b0;
        exp_rd_data = '0;
        for (int ch = 0; ch < nch; ch++) begin
            alloc_out[ch] = 0;
            rsv_out[ch]   = 0;
        end
        reset     = 1'b1;
        wr_beat   = '0;
        alloc     = '0;
        drain_rsv = '0;
        drain     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        wait_cycles = 0;
        while (wr_ready !== 1'b1) begin
            if (wait_cycles == ready_timeout) begin
                $display("Timeout: wr_ready stayed low after reset");
                fail_and_stop();
            end
            @(negedge clk);
            wait_cycles++;
        end

        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            check_outputs(cyc);
            // Alternate fill and drain phases so channels reach full and empty
            if ((cyc / 250) % 2 == 0) begin
                write_pct = 80;
                drain_pct = 15;
            end else begin
                write_pct = 30;
                drain_pct = 85;
            end

            if (holding) begin                 // Held beat keeps its ID and data
                hold_cycles++;
                if (hold_cycles > hold_timeout) begin
                    $display("Timeout: held beat on channel %0d was never accepted",
                             wr_beat.id);
                    fail_and_stop();
                end
            end else begin
                hold_cycles   = 0;
                wr_beat.valid = ($urandom % 100) < write_pct;
                wr_beat.id    = buffer_pkg::channel_id_t'($urandom);
                wr_beat.data  = buffer_pkg::data_t'($urandom);
            end

            drain = '0;
            pick  = buffer_pkg::channel_id_t'($urandom);
            if (($urandom % 100) < drain_pct && model_q[pick].size() != 0) begin
                drain.drain = 1'b1;
                drain.id    = pick;
            end

            #1;                                // Let the ready mux settle
            check_flag($sformatf("wr_ready id %0d cycle %0d", wr_beat.id, cyc),
                       model_q[wr_beat.id].size() < depth, wr_ready);
            pushed  = wr_beat.valid && model_q[wr_beat.id].size() < depth;
            holding = wr_beat.valid && !pushed;

            // Allocation sized so that a same-cycle unallocated beat still fits
            alloc = '0;
            pick  = buffer_pkg::channel_id_t'($urandom);
            limit = depth - model_q[pick].size() - alloc_out[pick];
            if (pushed && wr_beat.id == pick && alloc_out[pick] == 0) limit--;
            if (($urandom % 100) < 12 && limit > 0) begin
                alloc.req  = 1'b1;
                alloc.id   = pick;
                alloc.size = buffer_pkg::size_t'(1 + $urandom % limit);
            end

            drain_rsv = '0;
            pick      = buffer_pkg::channel_id_t'($urandom);
            limit     = model_q[pick].size() - rsv_out[pick];
            if (drain.drain && drain.id == pick && rsv_out[pick] == 0) limit--;
            if (($urandom % 100) < 12 && limit > 0) begin
                drain_rsv.req  = 1'b1;
                drain_rsv.id   = pick;
                drain_rsv.size = buffer_pkg::size_t'(1 + $urandom % limit);
            end

            // Model state after the coming rising edge
            if (drain.drain) begin
                exp_rd_data = model_q[drain.id].pop_front();
                if (rsv_out[drain.id] != 0) rsv_out[drain.id]--;
            end
            if (drain_rsv.req) rsv_out[drain_rsv.id] += int'(drain_rsv.size);
            if (pushed) begin
                model_q[wr_beat.id].push_back(wr_beat.data);
                if (alloc_out[wr_beat.id] != 0) alloc_out[wr_beat.id]--;
            end
            if (alloc.req) alloc_out[alloc.id] += int'(alloc.size);

            @(negedge clk);
        end
        check_outputs(num_cycles);

        $display("Testbench passed");
        $finish;
    end

endmodule : sram_controller_tb

`default_nettype wire

// ==== source/buffer_pkg.sv ====
`default_nettype none

package buffer_pkg;

    // ======================================================================
    // Geometry
    // ======================================================================

    localparam int num_channels = 4;            // Independent FIFOs
    localparam int data_width   = 32;           // Beat payload width
    localparam int buffer_depth = 16;           // Entries per channel
    localparam int size_width   = 8;            // Beat count field of a request

    // Derived widths
    localparam int id_width    = $clog2(num_channels);
    localparam int ptr_width   = $clog2(buffer_depth);
    localparam int level_width = ptr_width + 1;     // Must hold 0 up to depth

    // ======================================================================
    // Vector types
    // ======================================================================

    typedef logic [id_width-1:0]    channel_id_t;   // Channel index
    typedef logic [data_width-1:0]  data_t;         // One beat
    typedef logic [level_width-1:0] level_t;        // Occupancy, free space, reservations
    typedef logic [size_width-1:0]  size_t;         // Requested beats
    typedef logic [ptr_width-1:0]   ptr_t;          // FIFO pointer, wraps at depth

endpackage : buffer_pkg

`default_nettype wire

// ==== source/channel_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,         // Accepted beat
    input  buffer_pkg::data_t  wr_data,      // Shared write bus
    input  logic               alloc_req,
    input  buffer_pkg::size_t  alloc_size,
    input  logic               rsv_req,
    input  buffer_pkg::size_t  rsv_size,
    input  logic               pop,          // Drain of this channel
    output buffer_pkg::data_t  head,         // Oldest entry
    output logic               full,
    output logic               nonempty,
    output buffer_pkg::level_t space_free,   // Net of outstanding allocation
    output buffer_pkg::level_t data_avail    // Net of outstanding drain reservation
);

    // Storage
    buffer_pkg::data_t  mem [buffer_pkg::buffer_depth];
    buffer_pkg::ptr_t   wr_ptr;
    buffer_pkg::ptr_t   rd_ptr;

    // Counters
    buffer_pkg::level_t count;               // Occupancy
    buffer_pkg::level_t alloc_out;           // Space reserved for beats not yet arrived
    buffer_pkg::level_t rsv_out;             // Data reserved for beats not yet drained
    buffer_pkg::level_t alloc_next;
    buffer_pkg::level_t rsv_next;

    // ======================================================================
    // Reservation counter next state
    // ======================================================================

    always_comb begin
        alloc_next = alloc_out;
        if (alloc_req) begin
            alloc_next = alloc_next + buffer_pkg::level_t'(alloc_size);
        end
        // A beat consumes one unit of allocation while any is left
        if (push && alloc_out != '0) begin
            alloc_next = alloc_next - 1'b1;
        end
    end

    always_comb begin
        rsv_next = rsv_out;
        if (rsv_req) begin
            rsv_next = rsv_next + buffer_pkg::level_t'(rsv_size);
        end
        if (pop && rsv_out != '0) begin
            rsv_next = rsv_next - 1'b1;      // Drain settles one reserved beat
        end
    end

    // ======================================================================
    // State update
    // ======================================================================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;          // Beat lands at the tail
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            alloc_out <= '0;
            rsv_out   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;     // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + buffer_pkg::level_t'(push) - buffer_pkg::level_t'(pop);
            alloc_out <= alloc_next;
            rsv_out   <= rsv_next;
        end
    end

    // Levels seen by both engines
    assign head       = mem[rd_ptr];
    assign full       = (count == buffer_pkg::level_t'(buffer_pkg::buffer_depth));
    assign nonempty   = (count != '0);
    assign space_free = buffer_pkg::level_t'(buffer_pkg::buffer_depth) - count - alloc_out;
    assign data_avail = count - rsv_out;

    // ======================================================================
    // Protocol checks
    // ======================================================================

    // Decode must never push into a full channel
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
    // Consumer drains only while rd_valid is high
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> nonempty);
    // Producer stays within the space it was offered
    a_alloc_fits: assert property (@(posedge clk) disable iff (reset)
        alloc_req |-> alloc_size <= buffer_pkg::size_t'(space_free));
    a_rsv_fits: assert property (@(posedge clk) disable iff (reset)
        rsv_req |-> rsv_size <= buffer_pkg::size_t'(data_avail));

endmodule : channel_buffer

`default_nettype wire

// ==== source/channel_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel_decode (
    input  flow_pkg::write_beat_t                wr_beat,
    input  flow_pkg::alloc_req_t                 alloc,
    input  flow_pkg::drain_req_t                 drain_rsv,
    input  flow_pkg::drain_cmd_t                 drain,
    input  logic [buffer_pkg::num_channels-1:0]  chan_full,   // Per-channel full level
    output logic [buffer_pkg::num_channels-1:0]  wr_push,     // Qualified write strobe
    output logic [buffer_pkg::num_channels-1:0]  alloc_hit,
    output logic [buffer_pkg::num_channels-1:0]  rsv_hit,
    output logic [buffer_pkg::num_channels-1:0]  pop,
    output logic                                 wr_ready
);

    // ======================================================================
    // ID to one-hot strobes
    // ======================================================================

    always_comb begin
        wr_push   = '0;
        alloc_hit = '0;
        rsv_hit   = '0;
        pop       = '0;
        for (int i = 0; i < buffer_pkg::num_channels; i++) begin
            // Beat is pushed only while its channel has room
            if (wr_beat.valid && wr_beat.id == buffer_pkg::channel_id_t'(i)) begin
                wr_push[i] = !chan_full[i];
            end
            if (alloc.req && alloc.id == buffer_pkg::channel_id_t'(i)) begin
                alloc_hit[i] = 1'b1;
            end
            if (drain_rsv.req && drain_rsv.id == buffer_pkg::channel_id_t'(i)) begin
                rsv_hit[i] = 1'b1;
            end
            if (drain.drain && drain.id == buffer_pkg::channel_id_t'(i)) begin
                pop[i] = 1'b1;             // Pop strobe to buffer and bridge
            end
        end
    end

    // ======================================================================
    // Ready mux
    // ======================================================================

    // Not-full of the addressed channel, independent of valid
    assign wr_ready = !chan_full[wr_beat.id];

endmodule : channel_decode

`default_nettype wire

// ==== source/flow_pkg.sv ====
`default_nettype none

package flow_pkg;

    // ======================================================================
    // Request and beat bundles, all tagged with a channel ID
    // ======================================================================

    // Incoming beat from the read-side engine
    typedef struct packed {
        logic                    valid;
        buffer_pkg::channel_id_t id;
        buffer_pkg::data_t       data;
    } write_beat_t;

    // Space reservation by the producer
    typedef struct packed {
        logic                    req;     // Single-cycle strobe
        buffer_pkg::channel_id_t id;
        buffer_pkg::size_t       size;    // Beats to reserve
    } alloc_req_t;

    // Data reservation by the consumer
    typedef struct packed {
        logic                    req;
        buffer_pkg::channel_id_t id;
        buffer_pkg::size_t       size;
    } drain_req_t;

    // Pop one beat from one channel
    typedef struct packed {
        logic                    drain;
        buffer_pkg::channel_id_t id;
    } drain_cmd_t;

endpackage : flow_pkg

`default_nettype wire

// ==== source/read_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_bridge (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [buffer_pkg::num_channels-1:0]           pop,     // One-hot drain
    input  buffer_pkg::data_t [buffer_pkg::num_channels-1:0] heads,   // Head of each FIFO
    output buffer_pkg::data_t                             rd_data  // Registered result
);

    buffer_pkg::data_t sel_data;             // Head of the popped channel
    logic              any_pop;

    // ======================================================================
    // Head select
    // ======================================================================

    always_comb begin
        sel_data = '0;
        for (int i = 0; i < buffer_pkg::num_channels; i++) begin
            if (pop[i]) begin
                sel_data = heads[i];
            end
        end
    end

    assign any_pop = |pop;

    // ======================================================================
    // Result register
    // ======================================================================

    // Captured on the drain edge, held until the next drain
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (any_pop) begin
            rd_data <= sel_data;
        end
    end

    // Only one channel drains per cycle
    a_pop_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(pop));

endmodule : read_bridge

`default_nettype wire

// ==== source/sram_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_controller (
    input  logic                                              clk,
    input  logic                                              reset,
    input  flow_pkg::write_beat_t                             wr_beat,     // From read engine
    input  flow_pkg::alloc_req_t                              alloc,
    input  flow_pkg::drain_req_t                              drain_rsv,
    input  flow_pkg::drain_cmd_t                              drain,       // From write engine
    output logic                                              wr_ready,
    output buffer_pkg::level_t [buffer_pkg::num_channels-1:0] space_free,
    output buffer_pkg::level_t [buffer_pkg::num_channels-1:0] data_avail,
    output logic [buffer_pkg::num_channels-1:0]               rd_valid,    // Channel nonempty
    output buffer_pkg::data_t                                 rd_data
);

    // Decoded per-channel strobes
    logic [buffer_pkg::num_channels-1:0]               wr_push;
    logic [buffer_pkg::num_channels-1:0]               alloc_hit;
    logic [buffer_pkg::num_channels-1:0]               rsv_hit;
    logic [buffer_pkg::num_channels-1:0]               pop_hit;
    logic [buffer_pkg::num_channels-1:0]               chan_full;
    buffer_pkg::data_t [buffer_pkg::num_channels-1:0]  heads;

    // ======================================================================
    // Decode
    // ======================================================================

    channel_decode u_decode (
        .wr_beat   (wr_beat),
        .alloc     (alloc),
        .drain_rsv (drain_rsv),
        .drain     (drain),
        .chan_full (chan_full),
        .wr_push   (wr_push),
        .alloc_hit (alloc_hit),
        .rsv_hit   (rsv_hit),
        .pop       (pop_hit),
        .wr_ready  (wr_ready)
    );

    // ======================================================================
    // Per-channel FIFOs
    // ======================================================================

    for (genvar i = 0; i < buffer_pkg::num_channels; i++) begin : gen_channel
        channel_buffer u_buffer (
            .clk        (clk),
            .reset      (reset),
            .push       (wr_push[i]),
            .wr_data    (wr_beat.data),      // Shared across channels
            .alloc_req  (alloc_hit[i]),
            .alloc_size (alloc.size),        // Shared, only the hit channel uses it
            .rsv_req    (rsv_hit[i]),
            .rsv_size   (drain_rsv.size),
            .pop        (pop_hit[i]),
            .head       (heads[i]),
            .full       (chan_full[i]),
            .nonempty   (rd_valid[i]),
            .space_free (space_free[i]),
            .data_avail (data_avail[i])
        );
    end

    // ======================================================================
    // Latency bridge
    // ======================================================================

    read_bridge u_bridge (
        .clk     (clk),
        .reset   (reset),
        .pop     (pop_hit),
        .heads   (heads),
        .rd_data (rd_data)
    );

endmodule : sram_controller

`default_nettype wire

// ==== verilog.f ====
source/buffer_pkg.sv
source/flow_pkg.sv
source/channel_decode.sv
source/channel_buffer.sv
source/read_bridge.sv
source/sram_controller.sv
sim/sram_controller_tb.sv
